/* pdp8core_config.svh */
// PDP-8/L style core build constants
// word size, core depth, auto-index window and assertion enable

`ifndef PDP8CORE_CONFIG_SVH
`define PDP8CORE_CONFIG_SVH

// machine word and local core size
`define PDP8_WORD_BITS      12
`define PDP8_MEM_WORDS      4096

// a defer through 0010..0017 bumps the pointer
`define PDP8_AUTOINDEX_LO   12'o0010
`define PDP8_AUTOINDEX_HI   12'o0017

`define PDP8_ASSERT_ON      1       // 1 turns on the RTL assertions

`endif

/* pdp8core_pkg.sv */
// PDP-8/L style core shared types
// machine word, opcode and state encodings, console and status bundles

`default_nettype none

`include "pdp8core_config.svh"

package pdp8core_pkg;

    typedef logic [`PDP8_WORD_BITS-1:0] word_t;

    // instruction class in bits 11..9
    typedef enum logic [2:0] {
        OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS, OP_JMP, OP_IOT, OP_OPR
    } opcode_e;

    typedef enum logic [2:0] {
        MS_HALT, MS_FETCH, MS_DEFER, MS_EXEC, MS_DEPOSIT, MS_EXAMINE
    } majorState_e;

    typedef enum logic [2:0] {
        TS_IDLE, TS1, TS2, TS3, TS4
    } timeState_e;

    typedef enum logic [2:0] {
        CON_LOAD_ADDR, CON_DEPOSIT, CON_EXAMINE, CON_START, CON_CONT
    } consoleOp_e;

    typedef struct packed {
        consoleOp_e op;
        word_t      data;           // address or deposit word
    } consoleCmd_t;

    typedef struct packed {
        majorState_e majState;
        timeState_e  tState;
    } cycle_t;

    typedef struct packed {
        opcode_e opcode;
        logic    indirect;          // bit 8 of the instruction
        logic    isHalt;            // group 2 with HLT set
        logic    isIot;
    } instrInfo_t;

    typedef struct packed {
        word_t acum;
        logic  link;
        logic  skip;
    } operateResult_t;

    typedef struct packed {
        logic    run;
        word_t   acum;
        logic    link;
        word_t   pc;
        word_t   ma;
        word_t   mb;
        opcode_e ir;
        cycle_t  cycle;
    } procStatus_t;

endpackage

`default_nettype wire

/* pdp8core_operate.sv */
// PDP-8/L style operate unit
// group 1 and group 2 results, TAD adder, AND mask and the ISZ skip

`default_nettype none

module pdp8core_operate (
    input  pdp8core_pkg::word_t           i_mbuf,
    input  pdp8core_pkg::word_t           i_acum,
    input  logic                          i_link,
    input  pdp8core_pkg::opcode_e         i_opcode,
    output pdp8core_pkg::operateResult_t  o_result
);
    import pdp8core_pkg::*;

    word_t g1Acum, g1AcumRaw, g2Acum, tadAcum;
    logic  g1Link, g1LinkRaw, g2Skip, tadLink;

    assign {tadLink, tadAcum} = {i_link, i_acum} + {1'b0, i_mbuf};   // carry flips link

    always_comb begin
        // cla/cll first, then cma/cml, then iac
        {g1LinkRaw, g1AcumRaw} = {(i_mbuf[6] ? 1'b0 : i_link) ^ i_mbuf[4],
                                  (i_mbuf[7] ? 12'o0000 : i_acum) ^ {12{i_mbuf[5]}}}
                                 + {12'b0, i_mbuf[0]};
        case (i_mbuf[3:1])
            3'd1:    {g1Link, g1Acum} = {g1LinkRaw, g1AcumRaw[5:0], g1AcumRaw[11:6]};  // bsw
            3'd2:    {g1Link, g1Acum} = {g1AcumRaw, g1LinkRaw};                        // ral
            3'd3:    {g1Link, g1Acum} = {g1AcumRaw[10:0], g1LinkRaw, g1AcumRaw[11]};   // rtl
            3'd4:    {g1Link, g1Acum} = {g1AcumRaw[0], g1LinkRaw, g1AcumRaw[11:1]};    // rar
            3'd5:    {g1Link, g1Acum} = {g1AcumRaw[1:0], g1LinkRaw, g1AcumRaw[11:2]};  // rtr
            default: {g1Link, g1Acum} = {g1LinkRaw, g1AcumRaw};                        // no rotate
        endcase
    end

    // sma / sza / snl, bit 3 reverses the sense
    assign g2Skip = ((i_mbuf[6] & i_acum[11]) |
                     (i_mbuf[5] & (i_acum == '0)) |
                     (i_mbuf[4] & i_link)) ^ i_mbuf[3];
    assign g2Acum = i_mbuf[7] ? '0 : i_acum;

    always_comb begin
        o_result = '{acum: i_acum, link: i_link, skip: 1'b0};
        case (i_opcode)
            OP_AND: o_result.acum = i_acum & i_mbuf;
            OP_TAD: begin
                o_result.acum = tadAcum;
                o_result.link = tadLink;
            end
            OP_ISZ: o_result.skip = (i_mbuf == '0);     // MB already incremented
            OP_OPR: begin
                if (!i_mbuf[8]) begin
                    o_result.acum = g1Acum;
                    o_result.link = g1Link;
                end else if (!i_mbuf[0]) begin          // group 3 left alone
                    o_result.acum = g2Acum;
                    o_result.skip = g2Skip;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* pdp8core_memory.sv */
// PDP-8/L style 4K local core
// read into the output register in TS1, MB written back in TS3

`default_nettype none

`include "pdp8core_config.svh"

module pdp8core_memory (
    input  logic                 CLOCK,
    input  pdp8core_pkg::cycle_t i_cycle,
    input  pdp8core_pkg::word_t  i_addr,
    input  pdp8core_pkg::word_t  i_writeData,
    output pdp8core_pkg::word_t  o_readData
);
    import pdp8core_pkg::*;

    word_t core [`PDP8_MEM_WORDS];  // block ram

    always_ff @(posedge CLOCK) begin
        if (i_cycle.tState == TS1) o_readData <= core[i_addr];     // valid through TS2
        if (i_cycle.tState == TS3) core[i_addr] <= i_writeData;     // restore or modified word
    end

endmodule

`default_nettype wire

/* pdp8core_registers.sv */
// PDP-8/L style register file: AC, L, PC, MA, MB and IR
// MB is loaded and modified in TS2, AC/L/PC/MA are finished in TS4

`default_nettype none

`include "pdp8core_config.svh"

module pdp8core_registers (
    input  logic                          CLOCK,
    input  logic                          RESET,
    input  pdp8core_pkg::cycle_t          i_cycle,
    input  pdp8core_pkg::consoleCmd_t     i_consoleCmd,
    input  logic                          i_consoleStrobe,
    input  pdp8core_pkg::word_t           i_readData,
    input  pdp8core_pkg::operateResult_t  i_opResult,
    output pdp8core_pkg::instrInfo_t      o_instr,
    output pdp8core_pkg::word_t           o_mbuf,
    output pdp8core_pkg::word_t           o_acum,
    output logic                          o_link,
    output pdp8core_pkg::procStatus_t     o_status
);
    import pdp8core_pkg::*;

    word_t      acum, pc, ma, mb;
    word_t      effAddr;
    logic       link;
    logic       autoIndex;
    instrInfo_t ir;

    function automatic instrInfo_t decodeInstr(input word_t w);
        instrInfo_t info;
        info.opcode   = opcode_e'(w[11:9]);
        info.indirect = w[8];
        info.isHalt   = (w[11:9] == 3'o7) && w[8] && !w[0] && w[1];  // group 2 HLT
        info.isIot    = (w[11:9] == 3'o6);
        return info;
    endfunction

    // page bit picks current page or page zero
    assign effAddr   = {(mb[7] ? ma[11:7] : 5'b0), mb[6:0]};
    assign autoIndex = (ma >= `PDP8_AUTOINDEX_LO) && (ma <= `PDP8_AUTOINDEX_HI);

    assign o_instr  = ir;
    assign o_mbuf   = mb;
    assign o_acum   = acum;
    assign o_link   = link;
    assign o_status = '{run: 1'b0, acum: acum, link: link, pc: pc, ma: ma, mb: mb,
                        ir: ir.opcode, cycle: i_cycle};    // run merged at top

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            acum <= '0;
            link <= 1'b0;
            pc   <= '0;
            ma   <= '0;
            mb   <= '0;
            ir   <= '0;
        end else if (i_consoleStrobe) begin
            case (i_consoleCmd.op)
                CON_LOAD_ADDR: begin
                    pc <= i_consoleCmd.data;
                    ma <= i_consoleCmd.data;
                end
                CON_DEPOSIT, CON_EXAMINE: begin
                    ma <= pc;
                    pc <= pc + 1'b1;
                end
                CON_START: begin
                    ma   <= pc;
                    acum <= '0;
                    link <= 1'b0;
                end
                default: ma <= pc;              // continue
            endcase
        end else begin
            case (i_cycle.tState)
                TS_IDLE: if (i_cycle.majState == MS_FETCH) ma <= pc;

                TS2: case (i_cycle.majState)
                    MS_FETCH: begin
                        mb <= i_readData;
                        ir <= decodeInstr(i_readData);
                        pc <= pc + 1'b1;
                    end
                    MS_DEFER: mb <= i_readData + (autoIndex ? 12'd1 : 12'd0);
                    MS_EXEC: case (ir.opcode)
                        OP_ISZ:  mb <= i_readData + 1'b1;
                        OP_DCA:  mb <= acum;
                        OP_JMS:  mb <= pc;      // return address
                        default: mb <= i_readData;
                    endcase
                    MS_DEPOSIT: mb <= i_consoleCmd.data;    // host holds data under req
                    default:    mb <= i_readData;
                endcase

                TS4: case (i_cycle.majState)
                    MS_FETCH: if (!ir.isIot) begin          // iot is a bare fetch
                        case (ir.opcode)
                            OP_JMP: begin
                                if (ir.indirect) ma <= effAddr;
                                else pc <= effAddr;
                            end
                            OP_OPR: begin
                                acum <= i_opResult.acum;
                                link <= i_opResult.link;
                                if (i_opResult.skip) pc <= pc + 1'b1;
                            end
                            default: ma <= effAddr;         // and..jms
                        endcase
                    end
                    MS_DEFER: begin
                        if (ir.opcode == OP_JMP) pc <= mb;
                        else ma <= mb;
                    end
                    MS_EXEC: case (ir.opcode)
                        OP_AND, OP_TAD: begin
                            acum <= i_opResult.acum;
                            link <= i_opResult.link;
                        end
                        OP_ISZ: if (i_opResult.skip) pc <= pc + 1'b1;
                        OP_DCA: acum <= '0;
                        OP_JMS: pc <= ma + 1'b1;
                        default: ;
                    endcase
                    default: ;
                endcase

                default: ;
            endcase
        end
    end

    if (`PDP8_ASSERT_ON) begin : gAssert
        // MB only changes on the clock that closes TS2
        mbInTs2: assert property (@(posedge CLOCK) disable iff (RESET)
            !$past(RESET) && (mb != $past(mb)) |-> $past(i_cycle.tState) == TS2);
    end

endmodule

`default_nettype wire

/* pdp8core_control.sv */
// PDP-8/L style major state and time state sequencer
// picks the next major state in TS3 and serves the console req/ack port while halted

`default_nettype none

`include "pdp8core_config.svh"

module pdp8core_control (
    input  logic                          CLOCK,
    input  logic                          RESET,
    input  logic                          i_consoleReq,
    input  pdp8core_pkg::consoleCmd_t     i_consoleCmd,
    input  pdp8core_pkg::instrInfo_t      i_instr,
    input  pdp8core_pkg::word_t           i_mbuf,
    input  pdp8core_pkg::operateResult_t  i_opResult,
    output logic                          o_consoleAck,
    output logic                          o_consoleStrobe,
    output pdp8core_pkg::cycle_t          o_cycle,
    output logic                          o_run
);
    import pdp8core_pkg::*;

    majorState_e majState;
    majorState_e nextMajor;         // latched in TS3, taken in TS4
    majorState_e decidedMajor;
    timeState_e  tState;
    logic        cmdActive;         // command taken, ack not yet dropped
    logic        haltIdle;

    assign o_cycle  = '{majState: majState, tState: tState};
    assign haltIdle = (majState == MS_HALT) && (tState == TS_IDLE);

    // console is only looked at between cycles while halted
    assign o_consoleStrobe = i_consoleReq && !cmdActive && haltIdle;

    ////////////////////////////////////////
    // next major state
    ////////////////////////////////////////

    always_comb begin
        decidedMajor = MS_HALT;     // deposit and examine fall back to halt
        case (majState)
            MS_FETCH: begin
                if (i_instr.opcode == OP_JMP)
                    decidedMajor = i_mbuf[8] ? MS_DEFER : MS_FETCH;
                else if (i_instr.opcode inside {OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS})
                    decidedMajor = i_mbuf[8] ? MS_DEFER : MS_EXEC;
                else if (i_instr.isHalt)
                    decidedMajor = MS_HALT;
                else
                    decidedMajor = MS_FETCH;    // opr, iot
            end
            MS_DEFER: decidedMajor = (i_instr.opcode == OP_JMP) ? MS_FETCH : MS_EXEC;
            MS_EXEC:  decidedMajor = MS_FETCH;
            default:  decidedMajor = MS_HALT;
        endcase
    end

    ////////////////////////////////////////
    // time states and handshake
    ////////////////////////////////////////

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            majState     <= MS_HALT;
            nextMajor    <= MS_HALT;
            tState       <= TS_IDLE;
            cmdActive    <= 1'b0;
            o_consoleAck <= 1'b0;
            o_run        <= 1'b0;
        end else begin
            case (tState)
                TS_IDLE: begin
                    if (majState != MS_HALT) begin
                        tState <= TS1;              // one idle clock between cycles
                    end else if (o_consoleStrobe) begin
                        cmdActive <= 1'b1;
                        case (i_consoleCmd.op)
                            CON_DEPOSIT: begin
                                majState <= MS_DEPOSIT;
                                tState   <= TS1;
                            end
                            CON_EXAMINE: begin
                                majState <= MS_EXAMINE;
                                tState   <= TS1;
                            end
                            CON_START, CON_CONT: begin
                                majState <= MS_FETCH;
                                tState   <= TS1;
                                o_run    <= 1'b1;
                            end
                            default: ;              // load address is register only
                        endcase
                    end
                end
                TS1: tState <= TS2;                 // core read
                TS2: tState <= TS3;                 // MB loaded and modified
                TS3: begin
                    nextMajor <= decidedMajor;      // decided while write-back runs
                    tState    <= TS4;
                end
                TS4: begin
                    majState <= nextMajor;
                    tState   <= TS_IDLE;
                    if (nextMajor == MS_HALT) o_run <= 1'b0;
                end
                default: tState <= TS_IDLE;
            endcase

            // four-phase ack rises once the command has run to halt
            if (o_consoleAck) begin
                if (!i_consoleReq) begin
                    o_consoleAck <= 1'b0;
                    cmdActive    <= 1'b0;
                end
            end else if (cmdActive && haltIdle) begin
                o_consoleAck <= 1'b1;
            end
        end
    end

    if (`PDP8_ASSERT_ON) begin : gAssert
        // ack stays up without req for one clock only
        ackFalls: assert property (@(posedge CLOCK) disable iff (RESET)
            o_consoleAck && !i_consoleReq |=> !o_consoleAck);
        majLegal: assert property (@(posedge CLOCK) disable iff (RESET)
            majState inside {MS_HALT, MS_FETCH, MS_DEFER, MS_EXEC, MS_DEPOSIT, MS_EXAMINE});
    end

endmodule

`default_nettype wire

/* pdp8core_top.sv */
// PDP-8/L style processor core top level
// sequencer, register file, operate unit and local core

`default_nettype none

module pdp8core_top (
    input  logic                      i_CLOCK,
    input  logic                      i_RESET,
    input  logic                      i_consoleReq,
    input  pdp8core_pkg::consoleCmd_t i_consoleCmd,
    output logic                      o_consoleAck,
    output pdp8core_pkg::procStatus_t o_status
);
    import pdp8core_pkg::*;

    cycle_t         cycle;          // major state plus time state, every clock
    instrInfo_t     instr;          // decoded IR
    operateResult_t opResult;
    procStatus_t    regStatus;
    word_t          mbuf;
    word_t          acum;
    word_t          readData;       // core output, valid in TS2
    logic           link;
    logic           run;
    logic           consoleStrobe;  // console command taken this clock

    pdp8core_control u_control (
        .CLOCK           (i_CLOCK),
        .RESET           (i_RESET),
        .i_consoleReq    (i_consoleReq),
        .i_consoleCmd    (i_consoleCmd),
        .i_instr         (instr),
        .i_mbuf          (mbuf),
        .i_opResult      (opResult),
        .o_consoleAck    (o_consoleAck),
        .o_consoleStrobe (consoleStrobe),
        .o_cycle         (cycle),
        .o_run           (run)
    );

    pdp8core_registers u_registers (
        .CLOCK           (i_CLOCK),
        .RESET           (i_RESET),
        .i_cycle         (cycle),
        .i_consoleCmd    (i_consoleCmd),
        .i_consoleStrobe (consoleStrobe),
        .i_readData      (readData),
        .i_opResult      (opResult),
        .o_instr         (instr),
        .o_mbuf          (mbuf),
        .o_acum          (acum),
        .o_link          (link),
        .o_status        (regStatus)
    );

    pdp8core_operate u_operate (
        .i_mbuf   (mbuf),
        .i_acum   (acum),
        .i_link   (link),
        .i_opcode (instr.opcode),
        .o_result (opResult)
    );

    pdp8core_memory u_memory (
        .CLOCK       (i_CLOCK),
        .i_cycle     (cycle),
        .i_addr      (regStatus.ma),
        .i_writeData (mbuf),
        .o_readData  (readData)
    );

    // run flag lives in the sequencer, the rest in the register file
    always_comb begin
        o_status     = regStatus;
        o_status.run = run;
    end

endmodule

`default_nettype wire

/* pdp8core_checker.sv */
// PDP-8/L style core checker
// watches the console handshake and o_status and compares each acked step with its expected values

`default_nettype none

module pdp8core_checker (
    input  logic                      CLOCK,
    input  logic                      RESET,
    input  logic                      i_consoleReq,
    input  logic                      i_consoleAck,
    input  logic                      i_done,
    input  pdp8core_pkg::procStatus_t i_status,
    input  pdp8core_pkg::consoleOp_e  i_op,
    input  logic [3:0]                i_checkMask,
    input  pdp8core_pkg::word_t       i_expAcum,
    input  logic                      i_expLink,
    input  pdp8core_pkg::word_t       i_expPc,
    input  pdp8core_pkg::word_t       i_expWord,
    output int                        o_errorCount,
    output int                        o_stepsChecked
);
    timeunit 1ns;
    timeprecision 1ps;
    import pdp8core_pkg::*;

    logic prevAck;
    logic sawRun;                   // run seen high while waiting for ack
    int   waitCount;                // negedges with req up and ack down
    int   stepErrs;

    initial begin
        o_errorCount   = 0;
        o_stepsChecked = 0;
    end

    task automatic compareField(input string name, input logic [11:0] got,
                                input logic [11:0] exp);
        if (got !== exp) begin
            $display("Mismatch step %0d %s: got %h expected %h",
                     o_stepsChecked, name, got, exp);
            stepErrs++;
        end
    endtask

    task automatic checkStep();
        int    latency;
        word_t expMa;
        latency  = waitCount + 1;
        stepErrs = 0;
        // MA keeps the last address the core used, load address sets it directly
        expMa = (i_op == CON_LOAD_ADDR) ? i_expPc : i_expPc - 12'd1;
        case (i_op)
            CON_LOAD_ADDR: if (latency != 2) begin
                $display("step %0d: load address acked after %0d clocks instead of 2",
                         o_stepsChecked, latency);
                stepErrs++;
            end
            CON_DEPOSIT, CON_EXAMINE: if (latency != 6) begin
                $display("step %0d: memory command acked after %0d clocks instead of 6",
                         o_stepsChecked, latency);
                stepErrs++;
            end
            default: begin                      // start and continue
                if (!sawRun) begin
                    $display("step %0d: ack came without the core ever running",
                             o_stepsChecked);
                    stepErrs++;
                end
                // the core stops on HLT which is an operate instruction
                compareField("o_status.ir", {9'b0, i_status.ir}, {9'b0, OP_OPR});
            end
        endcase
        if (i_status.run) begin
            $display("step %0d: ack raised while the core is still running", o_stepsChecked);
            stepErrs++;
        end
        // ack only comes back while halted between cycles
        compareField("o_status.cycle", {6'b0, i_status.cycle}, {6'b0, MS_HALT, TS_IDLE});
        compareField("o_status.ma", i_status.ma, expMa);
        if (i_checkMask[0]) compareField("o_status.acum", i_status.acum, i_expAcum);
        if (i_checkMask[1]) compareField("o_status.link", {11'b0, i_status.link},
                                         {11'b0, i_expLink});
        if (i_checkMask[2]) compareField("o_status.pc", i_status.pc, i_expPc);
        if (i_checkMask[3]) compareField("o_status.mb", i_status.mb, i_expWord);
        $display("step %0d %s: %s", o_stepsChecked, i_op.name(), stepErrs == 0 ? "ok" : "FAILED");
        o_errorCount   += stepErrs;
        o_stepsChecked += 1;
        waitCount = 0;
        sawRun    = 1'b0;
    endtask

    // DUT outputs change on the rising edge and are stable on the falling one
    always @(negedge CLOCK) begin
        if (RESET) begin
            prevAck   = 1'b0;
            sawRun    = 1'b0;
            waitCount = 0;
        end else begin
            if (i_consoleAck && !i_consoleReq) begin
                $display("step %0d: ack still high a clock after req dropped", o_stepsChecked);
                o_errorCount++;
            end
            if (prevAck && !i_consoleAck && i_consoleReq) begin
                $display("step %0d: ack dropped while req was still high", o_stepsChecked);
                o_errorCount++;
            end
            if (i_consoleReq && !i_consoleAck) begin
                waitCount++;
                if (i_status.run) sawRun = 1'b1;
            end
            if (!i_consoleReq) waitCount = 0;
            if (i_consoleAck && !prevAck) checkStep();    // ack rise closes a step
            prevAck = i_consoleAck;
        end
    end

    always @(posedge i_done)
        $display("steps checked %0d, errors %0d", o_stepsChecked, o_errorCount);

endmodule

`default_nettype wire

/* pdp8core_tb.sv */
// PDP-8/L style core testbench
// runs a table of console commands through the four-phase port, checks in pdp8core_checker

`default_nettype none

module pdp8core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pdp8core_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_STEP = 200;

    typedef struct packed {
        consoleOp_e op;
        word_t      data;
        logic [3:0] mask;           // word, pc, link, acum
        word_t      expAcum;
        logic       expLink;
        word_t      expPc;
        word_t      expWord;        // MB after deposit or examine
    } step_t;

    logic        CLOCK;
    logic        RESET;
    logic        consoleReq;
    logic        consoleAck;
    logic        allDone;
    consoleCmd_t consoleCmd;
    procStatus_t status;
    step_t       steps[$];
    step_t       cur;               // step now on the port
    word_t       progWords[$];
    word_t       modelPc;           // PC expected from the console rules
    int          cycleCount = 0;
    int          timeoutLimit = 0;
    int          gap;
    int          errorCount;
    int          stepsChecked;

    initial CLOCK = 1'b0;
    always #4 CLOCK = ~CLOCK;

    pdp8core_top u_dut (
        .i_CLOCK      (CLOCK),
        .i_RESET      (RESET),
        .i_consoleReq (consoleReq),
        .i_consoleCmd (consoleCmd),
        .o_consoleAck (consoleAck),
        .o_status     (status)
    );

    pdp8core_checker u_checker (
        .CLOCK          (CLOCK),
        .RESET          (RESET),
        .i_consoleReq   (consoleReq),
        .i_consoleAck   (consoleAck),
        .i_done         (allDone),
        .i_status       (status),
        .i_op           (cur.op),
        .i_checkMask    (cur.mask),
        .i_expAcum      (cur.expAcum),
        .i_expLink      (cur.expLink),
        .i_expPc        (cur.expPc),
        .i_expWord      (cur.expWord),
        .o_errorCount   (errorCount),
        .o_stepsChecked (stepsChecked)
    );

    task automatic addStep(input consoleOp_e op, input word_t data, input logic [3:0] mask,
                           input word_t ac, input logic l, input word_t pc, input word_t w);
        steps.push_back('{op: op, data: data, mask: mask, expAcum: ac, expLink: l,
                          expPc: pc, expWord: w});
    endtask

    task automatic loadAddr(input word_t a);
        modelPc = a;
        addStep(CON_LOAD_ADDR, a, 4'b0100, '0, 1'b0, a, '0);
    endtask

    // deposits progWords from address a upward, PC steps past each word
    task automatic loadProgram(input word_t a);
        loadAddr(a);
        foreach (progWords[i]) begin
            modelPc = modelPc + 12'd1;
            addStep(CON_DEPOSIT, progWords[i], 4'b1100, '0, 1'b0, modelPc, progWords[i]);
        end
    endtask

    task automatic examineNext(input word_t w, input word_t ac, input logic l);
        modelPc = modelPc + 12'd1;
        addStep(CON_EXAMINE, '0, 4'b1111, ac, l, modelPc, w);
    endtask

    task automatic runUntilHalt(input consoleOp_e op, input word_t ac, input logic l,
                                input word_t pc);
        addStep(op, '0, 4'b0111, ac, l, pc, '0);
        modelPc = pc;
    endtask

    task automatic buildTable();
        ////////////////////////////////////////
        // deposit and examine round trip
        progWords = '{12'o1234, 12'o4321, 12'o7070};
        loadProgram(12'o0300);
        loadAddr(12'o0300);
        examineNext(12'o1234, 12'o0000, 1'b0);
        examineNext(12'o4321, 12'o0000, 1'b0);
        examineNext(12'o7070, 12'o0000, 1'b0);
        ////////////////////////////////////////
        // TAD 7777 + 0003 carries into link, AND 0017, HLT, then DCA and HLT
        progWords = '{12'o7300, 12'o1250, 12'o1251, 12'o0252, 12'o7402, 12'o3253, 12'o7402};
        loadProgram(12'o0200);
        progWords = '{12'o7777, 12'o0003, 12'o0017};
        loadProgram(12'o0250);
        loadAddr(12'o0200);
        runUntilHalt(CON_START, 12'o0002, 1'b1, 12'o0205);
        runUntilHalt(CON_CONT, 12'o0000, 1'b1, 12'o0207);
        loadAddr(12'o0253);
        examineNext(12'o0002, 12'o0000, 1'b1);
        ////////////////////////////////////////
        // ISZ on 7777 skips the HLT, JMS 0430 stores 0403
        progWords = '{12'o2220, 12'o7402, 12'o4230, 12'o7402};
        loadProgram(12'o0400);
        progWords = '{12'o7777};
        loadProgram(12'o0420);
        progWords = '{12'o0000, 12'o7402};
        loadProgram(12'o0430);
        loadAddr(12'o0400);
        runUntilHalt(CON_START, 12'o0000, 1'b0, 12'o0432);
        loadAddr(12'o0420);
        examineNext(12'o0000, 12'o0000, 1'b0);
        loadAddr(12'o0430);
        examineNext(12'o0403, 12'o0000, 1'b0);
        ////////////////////////////////////////
        // JMP I 0010, pointer 0577 bumps to 0600
        progWords = '{12'o0577};
        loadProgram(12'o0010);
        progWords = '{12'o7402};
        loadProgram(12'o0600);
        progWords = '{12'o5410};
        loadProgram(12'o0500);
        loadAddr(12'o0500);
        runUntilHalt(CON_START, 12'o0000, 1'b0, 12'o0601);
        loadAddr(12'o0010);
        examineNext(12'o0600, 12'o0000, 1'b0);
        ////////////////////////////////////////
        // operate groups: IAC carry, skips, RAL, RTR, SMA, BSW, SPA
        progWords = '{12'o7341, 12'o7440, 12'o7402, 12'o7420, 12'o7402, 12'o7500,
                      12'o7402, 12'o7001, 12'o7004, 12'o7012, 12'o7500, 12'o7402,
                      12'o7002, 12'o7510, 12'o7402, 12'o7402};
        loadProgram(12'o0700);
        loadAddr(12'o0700);
        runUntilHalt(CON_START, 12'o0000, 1'b1, 12'o0707);
        runUntilHalt(CON_CONT, 12'o0040, 1'b1, 12'o0720);
        ////////////////////////////////////////
        // ISZ loop of 8 passes keeps the core busy while START waits for ack
        progWords = '{12'o7300, 12'o2220, 12'o5201, 12'o7402};
        loadProgram(12'o1000);
        progWords = '{12'o7770};
        loadProgram(12'o1020);
        loadAddr(12'o1000);
        runUntilHalt(CON_START, 12'o0000, 1'b0, 12'o1004);
        loadAddr(12'o1020);
        examineNext(12'o0000, 12'o0000, 1'b0);
    endtask

    // runaway guard, sized from the table
    always @(posedge CLOCK) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit + RESET_CYCLES) begin
            $display("timeout after %0d cycles, the console port stopped answering", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h38384b91));
        RESET      = 1'b1;
        consoleReq = 1'b0;
        consoleCmd = '0;
        cur        = '0;
        allDone    = 1'b0;
        modelPc    = '0;
        buildTable();
        timeoutLimit = steps.size() * CYCLES_PER_STEP;
        repeat (RESET_CYCLES) @(negedge CLOCK);
        RESET <= 1'b0;

        foreach (steps[i]) begin
            @(negedge CLOCK);
            cur        <= steps[i];
            consoleCmd <= '{op: steps[i].op, data: steps[i].data};
            consoleReq <= 1'b1;
            do @(negedge CLOCK); while (!consoleAck);
            consoleReq <= 1'b0;             // data stays put until the next command
            do @(negedge CLOCK); while (consoleAck);
            gap = $urandom % 4;             // idle gap between commands
            repeat (gap) @(negedge CLOCK);
        end

        allDone <= 1'b1;
        @(negedge CLOCK);
        @(negedge CLOCK);
        if (errorCount == 0 && stepsChecked == steps.size()) begin
            $display("sim passed");
        end else begin
            if (stepsChecked != steps.size())
                $display("only %0d of %0d steps were acknowledged", stepsChecked, steps.size());
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pdp8core.f */
+incdir+.
pdp8core_pkg.sv
pdp8core_operate.sv
pdp8core_memory.sv
pdp8core_registers.sv
pdp8core_control.sv
pdp8core_top.sv
pdp8core_checker.sv
pdp8core_tb.sv

/* Makefile */
# Verilator build and run for the PDP-8/L style core

VERILATOR ?= verilator
TOP       ?= pdp8core_tb
FLIST     ?= pdp8core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES   := $(filter-out +incdir+%,$(shell cat $(FLIST))) pdp8core_config.svh
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
